// ==== tb.f ====
+incdir+design
design/fifo_pkg.sv
design/fifo_producer.sv
design/fifo_buffer.sv
design/fifo_consumer.sv
design/fifo_top.sv
tests/fifo_asserts.sv
tests/fifo_tb.sv

// ==== tests/fifo_vectors.txt ====
// columns: write_en write_data(hex) read_en, one line per clock cycle
// a line starting with @ opens a named test block, each block ends with a drain
@order
1 1001 0
1 1002 0
1 1003 0
0 0000 1
1 1004 1
1 1005 1
0 0000 1
0 0000 1
1 1006 0
0 0000 1
@fill
1 2001 0
1 2002 0
1 2003 0
1 2004 0
1 2005 0
1 2006 0
1 2007 0
1 2008 0
1 2009 0
1 2f0a 0
1 2f0b 0
0 0000 1
0 0000 0
1 200c 0
1 2f0d 0
0 0000 0
@empty_reads
0 0000 1
0 0000 1
0 0000 1
1 3001 1
0 0000 1
0 0000 1
0 0000 1
1 3002 0
1 3003 1
0 0000 1
0 0000 1
0 0000 1
0 0000 1
@mixed
1 4001 1
1 4002 1
1 4003 0
0 0000 1
1 4004 1
1 4005 1
1 4006 0
1 4007 0
0 0000 0
0 0000 1
1 4008 1
0 0000 1
1 4009 1
1 400a 0
0 0000 1
1 400b 1

// ==== tests/fifo_tb.sv ====
// fifo testbench with clock, reset, vector stimulus, reference model and checks
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_tb;

	localparam int drain_limit = 40;

	logic                        write_clk;
	logic                        reset_rsync;
	logic                        write_en;
	logic [`FIFO_DATA_WIDTH-1:0] write_data;
	logic                        read_en;
	logic                        full;
	logic [`FIFO_DATA_WIDTH-1:0] read_data;
	logic                        empty;

	// reference model state
	logic [`FIFO_DATA_WIDTH-1:0] model_q [$];
	int                          credits;
	logic                        credit_back;
	logic                        stage_full;

	int    error_count;
	int    block_start_errors;
	int    tests_run;
	int    tests_failed;
	int    delivered;
	string block_name;

	fifo_top UUT (
		.write_clk   (write_clk),
		.reset_rsync (reset_rsync),
		.write_en    (write_en),
		.write_data  (write_data),
		.read_en     (read_en),
		.full        (full),
		.read_data   (read_data),
		.empty       (empty)
	);

	initial
	begin
		write_clk = 1'b0;
		forever #10 write_clk = ~write_clk;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic flag_error(input string msg);
		$display("ERR %0t: %s", $time, msg);
		error_count++;
	endtask

	// compare outputs against the model while they are stable
	task automatic check_outputs();
		if (full !== (credits == 0))
			flag_error($sformatf("full is %b, expected %b", full, credits == 0));
		if (empty !== !stage_full)
			flag_error($sformatf("empty is %b, expected %b", empty, !stage_full));
		if (stage_full && (read_data !== model_q[0]))
			flag_error($sformatf("read_data is %h, expected %h", read_data, model_q[0]));
	endtask

	// one clock with inputs driven after the falling edge and the model stepped at the rising edge
	task automatic run_cycle(
		input logic                        we,
		input logic [`FIFO_DATA_WIDTH-1:0] wd,
		input logic                        re
	);
		logic deliver;
		logic accept;
		logic pop;
		int   buf_count;
		write_en   = we;
		write_data = wd;
		read_en    = re;
		@(posedge write_clk);
		deliver   = re && stage_full;
		buf_count = model_q.size() - (stage_full ? 1 : 0);
		pop       = (buf_count > 0) && (!stage_full || deliver);
		accept    = we && (credits != 0);
		if (deliver)
		begin
			void'(model_q.pop_front());
			delivered++;
		end
		if (accept)
			model_q.push_back(wd);
		if (pop)
			stage_full = 1'b1;
		else if (deliver)
			stage_full = 1'b0;
		// returned credit lands one edge after the read
		credits     = credits - (accept ? 1 : 0) + (credit_back ? 1 : 0);
		credit_back = deliver;
		@(negedge write_clk);
		check_outputs();
	endtask

	// read until both the model and the DUT run dry
	task automatic drain_fifo();
		int waited;
		waited = 0;
		while ((model_q.size() != 0 || empty !== 1'b1) && waited < drain_limit)
		begin
			run_cycle(1'b0, '0, 1'b1);
			waited++;
		end
		if (model_q.size() != 0 || empty !== 1'b1)
		begin
			$display("timeout: the FIFO did not drain within %0d cycles", drain_limit);
			error_count++;
		end
	endtask

	task automatic insert_gap();
		int unsigned gap;
		gap = $urandom % 4;
		repeat (gap)
			run_cycle(1'b0, '0, 1'b0);
	endtask

	task automatic finish_block();
		int errs;
		drain_fifo();
		errs = error_count - block_start_errors;
		tests_run++;
		if (errs != 0)
		begin
			tests_failed++;
			$display("test %s done: %0d errors", block_name, errs);
		end
		else
			$display("test %s done: no errors", block_name);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int          fd;
		int          n;
		string       line;
		logic        vec_we;
		logic [`FIFO_DATA_WIDTH-1:0] vec_wd;
		logic        vec_re;

		reset_rsync  = 1'b1;
		write_en     = 1'b0;
		write_data   = '0;
		read_en      = 1'b0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;
		delivered    = 0;
		block_name   = "";
		void'($urandom(9));

		model_q.delete();
		credits     = `FIFO_CREDITS;
		credit_back = 1'b0;
		stage_full  = 1'b0;

		repeat (2) @(posedge write_clk);
		@(negedge write_clk);
		reset_rsync = 1'b0;

		// flags straight out of reset
		block_start_errors = error_count;
		if (empty !== 1'b1)
			flag_error($sformatf("empty is %b after reset, expected 1", empty));
		if (full !== 1'b0)
			flag_error($sformatf("full is %b after reset, expected 0", full));
		block_name = "reset";
		finish_block();
		block_name = "";

		fd = $fopen("tests/fifo_vectors.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the vector file tests/fifo_vectors.txt");
			error_count++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.getc(0) == "@")
				begin
					if (block_name != "")
						finish_block();
					n = $sscanf(line, "@%s", block_name);
					insert_gap();
					block_start_errors = error_count;
				end
				else if (line.getc(0) != "/")
				begin
					n = $sscanf(line, "%h %h %h", vec_we, vec_wd, vec_re);
					if (n == 3)
						run_cycle(vec_we, vec_wd, vec_re);
				end
			end
			if (block_name != "")
				finish_block();
			$fclose(fd);
		end

		$display("tests run %0d, tests failed %0d, errors %0d, words delivered %0d",
			tests_run, tests_failed, error_count, delivered);
		if (error_count == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/fifo_asserts.sv ====
// bound assertions on credit accounting, head stability and flag values after reset
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_asserts #(
	parameter logic flag_after_reset = 1'b0
) (
	input wire logic write_clk,
	input wire logic reset_rsync,
	input wire logic fire,
	input wire logic allowed,
	input wire logic flag
);

	////////////////////////////////////////
	// transfer legality
	////////////////////////////////////////

	// whatever a transfer leaves behind must still be legal on the next cycle
	transfer_follow_up: assert property (
		@(posedge write_clk) disable iff (reset_rsync)
		fire |=> allowed
	)
	else
		$error("transfer left an illegal state behind");

	////////////////////////////////////////
	// flag after reset
	////////////////////////////////////////

	flag_reset_value: assert property (
		@(posedge write_clk)
		reset_rsync |=> (flag == flag_after_reset)
	)
	else
		$error("flag holds the wrong value one cycle after reset");

endmodule

// a push at zero credits wraps the counter above its reset value
// a credit returned that was never spent pushes it there too
// full must come out of reset low
bind fifo_producer fifo_asserts #(
	.flag_after_reset (1'b0)
) u_producer_asserts (
	.write_clk   (write_clk),
	.reset_rsync (reset_rsync),
	.fire        (push.valid),
	.allowed     (credit_count < `FIFO_CREDITS),
	.flag        (full)
);

// only a pop takes a word away from the buffer head
// empty must come out of reset high
bind fifo_consumer fifo_asserts #(
	.flag_after_reset (1'b1)
) u_consumer_asserts (
	.write_clk   (write_clk),
	.reset_rsync (reset_rsync),
	.fire        (head.valid && !pop),
	.allowed     (head.valid),
	.flag        (empty)
);

`default_nettype wire

// ==== design/fifo_top.sv ====
// fifo top level wiring the producer, buffer and consumer together
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_top (
	input  wire logic                        write_clk,
	input  wire logic                        reset_rsync,
	input  wire logic                        write_en,
	input  wire logic [`FIFO_DATA_WIDTH-1:0] write_data,
	input  wire logic                        read_en,
	output logic                             full,
	output logic [`FIFO_DATA_WIDTH-1:0]      read_data,
	output logic                             empty
);

	// accepted word into the buffer
	fifo_pkg::word_beat_t push;

	// oldest buffered word toward the output stage
	fifo_pkg::word_beat_t head;

	logic pop;
	logic credit_return;

	////////////////////////////////////////
	// stages
	////////////////////////////////////////

	fifo_producer u_producer (
		.write_clk     (write_clk),
		.reset_rsync   (reset_rsync),
		.write_en      (write_en),
		.write_data    (write_data),
		.credit_return (credit_return),
		.push          (push),
		.full          (full)
	);

	fifo_buffer u_buffer (
		.write_clk   (write_clk),
		.reset_rsync (reset_rsync),
		.push        (push),
		.pop         (pop),
		.head        (head)
	);

	fifo_consumer u_consumer (
		.write_clk     (write_clk),
		.reset_rsync   (reset_rsync),
		.head          (head),
		.read_en       (read_en),
		.pop           (pop),
		.read_data     (read_data),
		.empty         (empty),
		.credit_return (credit_return)
	);

endmodule

`default_nettype wire

// ==== design/fifo_consumer.sv ====
// fifo output stage with pop control, read data, empty flag and credit return
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_consumer (
	input  wire logic                        write_clk,
	input  wire logic                        reset_rsync,
	input  fifo_pkg::word_beat_t             head,
	input  wire logic                        read_en,
	output logic                             pop,
	output logic [`FIFO_DATA_WIDTH-1:0]      read_data,
	output logic                             empty,
	output logic                             credit_return
);

	fifo_pkg::out_state_t        state;
	logic [`FIFO_DATA_WIDTH-1:0] out_data;
	logic                        deliver;

	// a word leaves only when one is actually presented
	assign deliver = read_en && (state == fifo_pkg::OUT_HOLDING);

	// refill when the stage is free or is being emptied this cycle
	assign pop = head.valid && ((state == fifo_pkg::OUT_EMPTY) || deliver);

	assign empty     = (state == fifo_pkg::OUT_EMPTY);
	assign read_data = out_data;

	////////////////////////////////////////
	// output stage state
	////////////////////////////////////////

	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			state <= fifo_pkg::OUT_EMPTY;
		end
		else if (pop)
		begin
			state <= fifo_pkg::OUT_HOLDING;
		end
		else if (deliver)
		begin
			state <= fifo_pkg::OUT_EMPTY;
		end
	end

	// loaded from the buffer head on every pop
	always_ff @(posedge write_clk)
	begin
		if (pop)
		begin
			out_data <= head.data;
		end
	end

	////////////////////////////////////////
	// credit return
	////////////////////////////////////////

	// one credit goes back per delivered word, a cycle after the read
	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			credit_return <= 1'b0;
		end
		else
		begin
			credit_return <= deliver;
		end
	end

endmodule

`default_nettype wire

// ==== design/fifo_buffer.sv ====
// fifo storage array with wrapping write and read pointers and head view
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_buffer (
	input  wire logic                 write_clk,
	input  wire logic                 reset_rsync,
	input  fifo_pkg::word_beat_t      push,
	input  wire logic                 pop,
	output fifo_pkg::word_beat_t      head
);

	logic [`FIFO_DATA_WIDTH-1:0] mem [0:`FIFO_DEPTH-1];

	logic [`FIFO_ADDR_WIDTH-1:0] write_ptr;
	logic [`FIFO_ADDR_WIDTH-1:0] read_ptr;

	// one extra bit so a completely filled buffer can be counted
	logic [`FIFO_ADDR_WIDTH:0]   count;

	////////////////////////////////////////
	// storage
	////////////////////////////////////////

	// the credit scheme keeps push away from a full buffer
	always_ff @(posedge write_clk)
	begin
		if (push.valid)
		begin
			mem[write_ptr] <= push.data;
		end
	end

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////

	// pointers wrap naturally since the depth is a power of two
	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			write_ptr <= '0;
			read_ptr  <= '0;
			count     <= '0;
		end
		else
		begin
			if (push.valid)
			begin
				write_ptr <= write_ptr + 1'b1;
			end
			if (pop)
			begin
				read_ptr <= read_ptr + 1'b1;
			end
			case ({push.valid, pop})
				2'b10:
				begin
					count <= count + 1'b1;
				end
				2'b01:
				begin
					count <= count - 1'b1;
				end
				default:
				begin
					count <= count;
				end
			endcase
		end
	end

	// oldest stored word, live as soon as it was written
	assign head.valid = (count != '0);
	assign head.data  = mem[read_ptr];

endmodule

`default_nettype wire

// ==== design/fifo_producer.sv ====
// fifo write front end with credit counter, full flag and push generation
`timescale 1ns/100ps
`default_nettype none

`include "fifo_consts.svh"

module fifo_producer (
	input  wire logic                        write_clk,
	input  wire logic                        reset_rsync,
	input  wire logic                        write_en,
	input  wire logic [`FIFO_DATA_WIDTH-1:0] write_data,
	input  wire logic                        credit_return,
	output fifo_pkg::word_beat_t             push,
	output logic                             full
);

	// credits still available to the writer
	logic [`FIFO_CREDIT_WIDTH-1:0] credit_count;
	logic                          accept;

	// out of credits means no room left anywhere downstream
	assign full = (credit_count == '0);

	// a write is taken only while a credit is held
	assign accept = write_en && !full;

	assign push.valid = accept;
	assign push.data  = write_data;

	////////////////////////////////////////
	// credit counter
	////////////////////////////////////////

	// an accept and a returned credit in one cycle cancel out
	always_ff @(posedge write_clk)
	begin
		if (reset_rsync)
		begin
			credit_count <= `FIFO_CREDIT_WIDTH'(`FIFO_CREDITS);
		end
		else
		begin
			case ({accept, credit_return})
				2'b10:
				begin
					credit_count <= credit_count - 1'b1;
				end
				2'b01:
				begin
					credit_count <= credit_count + 1'b1;
				end
				default:
				begin
					credit_count <= credit_count;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/fifo_pkg.sv ====
// fifo package with the word beat struct and the output stage state enum
`default_nettype none

`include "fifo_consts.svh"

package fifo_pkg;

	////////////////////////////////////////
	// word transport
	////////////////////////////////////////

	// one word moving between stages, valid marks a live beat
	typedef struct packed {
		logic                        valid;
		logic [`FIFO_DATA_WIDTH-1:0] data;
	} word_beat_t;

	////////////////////////////////////////
	// output stage
	////////////////////////////////////////

	// holding means read_data carries the oldest word
	typedef enum logic {
		OUT_EMPTY   = 1'b0,
		OUT_HOLDING = 1'b1
	} out_state_t;

endpackage

`default_nettype wire

// ==== design/fifo_consts.svh ====
// word width, buffer depth, pointer width and credit constants for the fifo
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// width of one data word
`define FIFO_DATA_WIDTH 16

// buffer entries, must stay a power of two so the pointers wrap on their own
`define FIFO_DEPTH 8
`define FIFO_ADDR_WIDTH 3

// one credit per buffer entry plus one for the output stage
`define FIFO_CREDITS (`FIFO_DEPTH + 1)
`define FIFO_CREDIT_WIDTH 4

`endif
